//--- shim_pkg.sv
package shim_pkg;

  // Board and word widths
  localparam int N_BOARDS = 8; // Amplifier boards in the shim system
  localparam int BOARD_W  = 3; // Board index
  localparam int STATE_W  = 4; // State code
  localparam int CODE_W   = 25; // Status code
  localparam int STATUS_W = 32; // {board, code, state}
  localparam int TIMER_W  = 32; // Sequencing counter

  // Sequencer states, numbering kept for software compatibility
  localparam logic [STATE_W-1:0] S_IDLE              = 4'd1;
  localparam logic [STATE_W-1:0] S_CONFIRM_SPI_RST   = 4'd2;
  localparam logic [STATE_W-1:0] S_POWER_ON_CTRL_BRD = 4'd3;
  localparam logic [STATE_W-1:0] S_CONFIRM_SPI_START = 4'd4;
  localparam logic [STATE_W-1:0] S_POWER_ON_AMP_BRD  = 4'd5;
  localparam logic [STATE_W-1:0] S_AMP_POWER_WAIT    = 4'd6;
  localparam logic [STATE_W-1:0] S_RUNNING           = 4'd7;
  localparam logic [STATE_W-1:0] S_HALTING           = 4'd8;
  localparam logic [STATE_W-1:0] S_HALTED            = 4'd9;

  // Basic system
  localparam logic [CODE_W-1:0] STS_EMPTY             = 25'h000;
  localparam logic [CODE_W-1:0] STS_OK                = 25'h001;
  localparam logic [CODE_W-1:0] STS_PS_SHUTDOWN       = 25'h002; // sys_en dropped
  // SPI subsystem
  localparam logic [CODE_W-1:0] STS_SPI_RESET_TIMEOUT = 25'h100;
  localparam logic [CODE_W-1:0] STS_SPI_START_TIMEOUT = 25'h101;
  // Configuration checks
  localparam logic [CODE_W-1:0] STS_LOCK_VIOL         = 25'h200;
  localparam logic [CODE_W-1:0] STS_SYS_EN_OOB        = 25'h201;
  localparam logic [CODE_W-1:0] STS_INTEG_WINDOW_OOB  = 25'h205;
  // Shutdown paths
  localparam logic [CODE_W-1:0] STS_SHUTDOWN_SENSE    = 25'h300; // Per board
  localparam logic [CODE_W-1:0] STS_EXT_SHUTDOWN      = 25'h301;
  // Integrator
  localparam logic [CODE_W-1:0] STS_OVER_THRESH       = 25'h400; // Per board
  // Trigger commands
  localparam logic [CODE_W-1:0] STS_BAD_TRIG_CMD      = 25'h500;
  // DAC channels, per board
  localparam logic [CODE_W-1:0] STS_DAC_BOOT_FAIL     = 25'h600;
  localparam logic [CODE_W-1:0] STS_BAD_DAC_CMD       = 25'h601;
  // ADC channels, per board
  localparam logic [CODE_W-1:0] STS_ADC_BOOT_FAIL     = 25'h700;
  localparam logic [CODE_W-1:0] STS_BAD_ADC_CMD       = 25'h701;

  // Minimum dwell before spi_off is trusted
  localparam logic [TIMER_W-1:0] SPI_SETTLE_CYCLES = 32'd10;

  // Delays in clock cycles at 100 MHz
  localparam logic [TIMER_W-1:0] DEF_FORCE_DELAY    = 32'd10000000;  // 100 ms after force release
  localparam logic [TIMER_W-1:0] DEF_RESET_PULSE    = 32'd10000;     // 100 us reset pulse
  localparam logic [TIMER_W-1:0] DEF_RESET_DELAY    = 32'd10000000;  // 100 ms amp power-up
  localparam logic [TIMER_W-1:0] DEF_SPI_RESET_WAIT = 32'd100000000; // 1 s for SPI off
  localparam logic [TIMER_W-1:0] DEF_SPI_START_WAIT = 32'd100000000; // 1 s for SPI start

endpackage

//--- shim_fault_encoder.sv
`timescale 1ns/100ps

module shim_fault_encoder (
  input  logic                             sys_en,
  input  logic                             lock_viol,
  input  logic                             sys_en_oob,
  input  logic                             integ_window_oob,
  input  logic                             ext_shutdown,
  input  logic                             bad_trig_cmd,
  input  logic [shim_pkg::N_BOARDS-1:0]    shutdown_sense,
  input  logic [shim_pkg::N_BOARDS-1:0]    over_thresh,
  input  logic [shim_pkg::N_BOARDS-1:0]    dac_boot_fail,
  input  logic [shim_pkg::N_BOARDS-1:0]    adc_boot_fail,
  input  logic [shim_pkg::N_BOARDS-1:0]    bad_dac_cmd,
  input  logic [shim_pkg::N_BOARDS-1:0]    bad_adc_cmd,
  output logic                             cfg_fault,
  output logic                             boot_fault,
  output logic                             run_fault,
  output logic [shim_pkg::CODE_W-1:0]      cfg_code,
  output logic [shim_pkg::CODE_W-1:0]      boot_code,
  output logic [shim_pkg::CODE_W-1:0]      run_code,
  output logic [shim_pkg::BOARD_W-1:0]     boot_board,
  output logic [shim_pkg::BOARD_W-1:0]     run_board
);

  // Index of lowest set bit, board 0 if none
  function automatic logic [shim_pkg::BOARD_W-1:0] low_board(
    input logic [shim_pkg::N_BOARDS-1:0] vec
  );
    logic [shim_pkg::BOARD_W-1:0] idx;
    idx = '0;
    for (int i = shim_pkg::N_BOARDS - 1; i >= 0; i--) begin
      if (vec[i]) idx = shim_pkg::BOARD_W'(i); // Scan down so lowest wins
    end
    return idx;
  endfunction

  // Pre-start checks, lock_viol only matters once running
  always_comb begin
    cfg_fault = sys_en_oob | integ_window_oob;
    if (sys_en_oob)            cfg_code = shim_pkg::STS_SYS_EN_OOB;
    else if (integ_window_oob) cfg_code = shim_pkg::STS_INTEG_WINDOW_OOB;
    else                       cfg_code = shim_pkg::STS_OK;
  end

  // Boot result, DAC before ADC
  always_comb begin
    boot_fault = (|dac_boot_fail) | (|adc_boot_fail);
    boot_board = '0;
    if (|dac_boot_fail) begin
      boot_code  = shim_pkg::STS_DAC_BOOT_FAIL;
      boot_board = low_board(dac_boot_fail);
    end else if (|adc_boot_fail) begin
      boot_code  = shim_pkg::STS_ADC_BOOT_FAIL;
      boot_board = low_board(adc_boot_fail);
    end else begin
      boot_code  = shim_pkg::STS_OK;
    end
  end

  // Running faults in fixed priority
  always_comb begin
    run_fault = !sys_en | lock_viol | (|shutdown_sense) | ext_shutdown
              | (|over_thresh) | bad_trig_cmd | (|bad_dac_cmd) | (|bad_adc_cmd);
    run_board = '0; // Single faults report board 0
    if (!sys_en)                run_code = shim_pkg::STS_PS_SHUTDOWN;
    else if (lock_viol)         run_code = shim_pkg::STS_LOCK_VIOL;
    else if (|shutdown_sense) begin
      run_code  = shim_pkg::STS_SHUTDOWN_SENSE;
      run_board = low_board(shutdown_sense);
    end
    else if (ext_shutdown)      run_code = shim_pkg::STS_EXT_SHUTDOWN;
    else if (|over_thresh) begin
      run_code  = shim_pkg::STS_OVER_THRESH;
      run_board = low_board(over_thresh);
    end
    else if (bad_trig_cmd)      run_code = shim_pkg::STS_BAD_TRIG_CMD;
    else if (|bad_dac_cmd) begin
      run_code  = shim_pkg::STS_BAD_DAC_CMD;
      run_board = low_board(bad_dac_cmd);
    end
    else if (|bad_adc_cmd) begin
      run_code  = shim_pkg::STS_BAD_ADC_CMD;
      run_board = low_board(bad_adc_cmd);
    end
    else                        run_code = shim_pkg::STS_OK;
  end

  // OR-reductions and priority chains must agree
  always_comb begin
    assert (cfg_fault == (cfg_code != shim_pkg::STS_OK)) else $error("cfg flag/code mismatch");
    assert (boot_fault == (boot_code != shim_pkg::STS_OK)) else $error("boot flag/code mismatch");
    assert (run_fault == (run_code != shim_pkg::STS_OK)) else $error("run flag/code mismatch");
  end

endmodule

//--- shim_seq_timer.sv
`timescale 1ns/100ps

module shim_seq_timer #(
  parameter logic [shim_pkg::TIMER_W-1:0] FORCE_DELAY    = shim_pkg::DEF_FORCE_DELAY,
  parameter logic [shim_pkg::TIMER_W-1:0] RESET_PULSE    = shim_pkg::DEF_RESET_PULSE,
  parameter logic [shim_pkg::TIMER_W-1:0] RESET_DELAY    = shim_pkg::DEF_RESET_DELAY,
  parameter logic [shim_pkg::TIMER_W-1:0] SPI_RESET_WAIT = shim_pkg::DEF_SPI_RESET_WAIT,
  parameter logic [shim_pkg::TIMER_W-1:0] SPI_START_WAIT = shim_pkg::DEF_SPI_START_WAIT
) (
  input  logic                         clk,
  input  logic                         aresetn,
  input  logic                         timer_clear, // State change this cycle
  input  logic [shim_pkg::STATE_W-1:0] state,
  output logic                         settled,
  output logic                         expired
);

  logic [shim_pkg::TIMER_W-1:0] count; // Cycles spent in current state
  logic [shim_pkg::TIMER_W-1:0] limit;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      count <= '0;
    end else if (timer_clear) begin
      count <= '0; // First cycle of new state sees zero
    end else if (count != '1) begin
      count <= count + 1'b1; // Stops at all-ones
    end
  end

  // Limit of the state being timed
  always_comb begin
    case (state)
      shim_pkg::S_CONFIRM_SPI_RST:   limit = SPI_RESET_WAIT;
      shim_pkg::S_POWER_ON_CTRL_BRD: limit = FORCE_DELAY;
      shim_pkg::S_CONFIRM_SPI_START: limit = SPI_START_WAIT;
      shim_pkg::S_POWER_ON_AMP_BRD:  limit = RESET_PULSE;
      shim_pkg::S_AMP_POWER_WAIT:    limit = RESET_DELAY;
      default:                       limit = '1; // Untimed states
    endcase
  end

  assign settled = (count >= shim_pkg::SPI_SETTLE_CYCLES);
  assign expired = (count >= limit);

  // Every state starts its count from zero
  a_clear_zero: assert property (@(posedge clk) disable iff (!aresetn)
    timer_clear |=> (count == '0));

endmodule

//--- shim_power_fsm.sv
`timescale 1ns/100ps

module shim_power_fsm (
  input  logic                          clk,
  input  logic                          aresetn,
  input  logic                          sys_en,
  input  logic                          spi_off,
  input  logic                          settled,
  input  logic                          expired,
  input  logic                          cfg_fault,
  input  logic                          boot_fault,
  input  logic                          run_fault,
  input  logic [shim_pkg::CODE_W-1:0]   cfg_code,
  input  logic [shim_pkg::CODE_W-1:0]   boot_code,
  input  logic [shim_pkg::CODE_W-1:0]   run_code,
  input  logic [shim_pkg::BOARD_W-1:0]  boot_board,
  input  logic [shim_pkg::BOARD_W-1:0]  run_board,
  output logic [shim_pkg::STATE_W-1:0]  state,
  output logic                          timer_clear,
  output logic                          unlock_cfg,        // Config registers writable
  output logic                          spi_clk_gate,      // SPI clock running
  output logic                          spi_en,
  output logic                          shutdown_sense_en,
  output logic                          block_buffers,     // Hold off PL buffer traffic
  output logic                          n_shutdown_force,
  output logic                          n_shutdown_rst,
  output logic                          ps_interrupt,
  output logic [shim_pkg::STATUS_W-1:0] status_word
);

  logic [shim_pkg::STATE_W-1:0] state_next;
  logic [shim_pkg::CODE_W-1:0]  status_code;
  logic [shim_pkg::BOARD_W-1:0] board_num;
  logic [shim_pkg::CODE_W-1:0]  halt_code;  // Code latched on the way to a halt
  logic [shim_pkg::BOARD_W-1:0] halt_board;

  assign status_word = {board_num, status_code, state};
  assign timer_clear = (state_next != state); // Timer restarts with each new state

  // Next state and halt cause
  always_comb begin
    state_next = state;
    halt_code  = shim_pkg::STS_EMPTY; // Only seen from an illegal state
    halt_board = '0;
    case (state)
      shim_pkg::S_IDLE: if (sys_en) begin
        if (cfg_fault) begin
          state_next = shim_pkg::S_HALTING;
          halt_code  = cfg_code;
        end else begin
          state_next = shim_pkg::S_CONFIRM_SPI_RST;
        end
      end
      shim_pkg::S_CONFIRM_SPI_RST: begin
        if (settled && spi_off) state_next = shim_pkg::S_POWER_ON_CTRL_BRD;
        else if (expired) begin
          state_next = shim_pkg::S_HALTING;
          halt_code  = shim_pkg::STS_SPI_RESET_TIMEOUT;
        end
      end
      shim_pkg::S_POWER_ON_CTRL_BRD:
        if (expired) state_next = shim_pkg::S_CONFIRM_SPI_START;
      shim_pkg::S_CONFIRM_SPI_START: begin
        if (!spi_off) state_next = shim_pkg::S_POWER_ON_AMP_BRD; // SPI came up
        else if (boot_fault) begin
          state_next = shim_pkg::S_HALTING;
          halt_code  = boot_code;
          halt_board = boot_board;
        end else if (expired) begin
          state_next = shim_pkg::S_HALTING;
          halt_code  = shim_pkg::STS_SPI_START_TIMEOUT;
        end
      end
      shim_pkg::S_POWER_ON_AMP_BRD:
        if (expired) state_next = shim_pkg::S_AMP_POWER_WAIT;
      shim_pkg::S_AMP_POWER_WAIT:
        if (expired) state_next = shim_pkg::S_RUNNING;
      shim_pkg::S_RUNNING:
        if (!ps_interrupt && run_fault) begin // Interrupt cycle masks faults
          state_next = shim_pkg::S_HALTING;
          halt_code  = run_code;
          halt_board = run_board;
        end
      shim_pkg::S_HALTING: state_next = shim_pkg::S_HALTED;
      shim_pkg::S_HALTED:  if (!sys_en) state_next = shim_pkg::S_IDLE;
      default:             state_next = shim_pkg::S_HALTED;
    endcase
  end

  // Outputs change on entry to a state
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= shim_pkg::S_IDLE;
      unlock_cfg        <= 1'b1;
      spi_clk_gate      <= 1'b0;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      block_buffers     <= 1'b1;
      n_shutdown_force  <= 1'b0; // Amps held off
      n_shutdown_rst    <= 1'b1;
      ps_interrupt      <= 1'b0;
      status_code       <= shim_pkg::STS_OK;
      board_num         <= '0;
    end else begin
      state        <= state_next;
      ps_interrupt <= 1'b0; // Pulses last one cycle
      if (timer_clear) begin
        case (state_next)
          shim_pkg::S_CONFIRM_SPI_RST:   unlock_cfg <= 1'b0; // Lock config
          shim_pkg::S_POWER_ON_CTRL_BRD: n_shutdown_force <= 1'b1;
          shim_pkg::S_CONFIRM_SPI_START: begin
            spi_en       <= 1'b1;
            spi_clk_gate <= 1'b1;
          end
          shim_pkg::S_POWER_ON_AMP_BRD:  n_shutdown_rst <= 1'b0; // Start of reset pulse
          shim_pkg::S_AMP_POWER_WAIT:    n_shutdown_rst <= 1'b1;
          shim_pkg::S_RUNNING: begin
            shutdown_sense_en <= 1'b1;
            block_buffers     <= 1'b0;
            ps_interrupt      <= 1'b1;
          end
          // HALTING entry, or HALTED straight from a bad state
          shim_pkg::S_HALTING, shim_pkg::S_HALTED: if (state != shim_pkg::S_HALTING) begin
            unlock_cfg        <= 1'b1;
            spi_clk_gate      <= 1'b0;
            spi_en            <= 1'b0;
            shutdown_sense_en <= 1'b0;
            block_buffers     <= 1'b1;
            n_shutdown_force  <= 1'b0;
            n_shutdown_rst    <= 1'b1;
            ps_interrupt      <= 1'b1;
            status_code       <= halt_code;
            board_num         <= halt_board;
          end
          shim_pkg::S_IDLE: begin
            status_code <= shim_pkg::STS_OK;
            board_num   <= '0;
          end
          default: ;
        endcase
      end
    end
  end

  // Buffers open only while running
  a_block_run: assert property (@(posedge clk) disable iff (!aresetn)
    !block_buffers |-> (state == shim_pkg::S_RUNNING));

  // Interrupt is strictly a single-cycle pulse
  a_irq_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt);

endmodule

//--- shim_hw_manager.sv
`timescale 1ns/100ps

module shim_hw_manager #(
  parameter logic [shim_pkg::TIMER_W-1:0] FORCE_DELAY    = shim_pkg::DEF_FORCE_DELAY,
  parameter logic [shim_pkg::TIMER_W-1:0] RESET_PULSE    = shim_pkg::DEF_RESET_PULSE,
  parameter logic [shim_pkg::TIMER_W-1:0] RESET_DELAY    = shim_pkg::DEF_RESET_DELAY,
  parameter logic [shim_pkg::TIMER_W-1:0] SPI_RESET_WAIT = shim_pkg::DEF_SPI_RESET_WAIT,
  parameter logic [shim_pkg::TIMER_W-1:0] SPI_START_WAIT = shim_pkg::DEF_SPI_START_WAIT
) (
  input  logic                          clk,
  input  logic                          aresetn,
  input  logic                          sys_en,
  input  logic                          spi_off,
  input  logic                          ext_shutdown,
  input  logic                          lock_viol,
  input  logic                          sys_en_oob,
  input  logic                          integ_window_oob,
  input  logic [shim_pkg::N_BOARDS-1:0] shutdown_sense,
  input  logic [shim_pkg::N_BOARDS-1:0] over_thresh,
  input  logic                          bad_trig_cmd,
  input  logic [shim_pkg::N_BOARDS-1:0] dac_boot_fail,
  input  logic [shim_pkg::N_BOARDS-1:0] bad_dac_cmd,
  input  logic [shim_pkg::N_BOARDS-1:0] adc_boot_fail,
  input  logic [shim_pkg::N_BOARDS-1:0] bad_adc_cmd,
  output logic                          unlock_cfg,
  output logic                          spi_clk_gate,
  output logic                          spi_en,
  output logic                          shutdown_sense_en,
  output logic                          block_buffers,
  output logic                          n_shutdown_force,
  output logic                          n_shutdown_rst,
  output logic [shim_pkg::STATUS_W-1:0] status_word,
  output logic                          ps_interrupt
);

  logic                         cfg_fault, boot_fault, run_fault;
  logic [shim_pkg::CODE_W-1:0]  cfg_code, boot_code, run_code;
  logic [shim_pkg::BOARD_W-1:0] boot_board, run_board;
  logic [shim_pkg::STATE_W-1:0] state;
  logic                         timer_clear, settled, expired;

  // Combinational fault priority
  shim_fault_encoder u_faults (
    .sys_en, .lock_viol, .sys_en_oob, .integ_window_oob, .ext_shutdown, .bad_trig_cmd,
    .shutdown_sense, .over_thresh, .dac_boot_fail, .adc_boot_fail, .bad_dac_cmd, .bad_adc_cmd,
    .cfg_fault, .boot_fault, .run_fault, .cfg_code, .boot_code, .run_code,
    .boot_board, .run_board
  );

  // Per-state delays
  shim_seq_timer #(
    .FORCE_DELAY(FORCE_DELAY), .RESET_PULSE(RESET_PULSE), .RESET_DELAY(RESET_DELAY),
    .SPI_RESET_WAIT(SPI_RESET_WAIT), .SPI_START_WAIT(SPI_START_WAIT)
  ) u_timer (
    .clk, .aresetn, .timer_clear, .state, .settled, .expired
  );

  // Sequencer with registered outputs
  shim_power_fsm u_fsm (
    .clk, .aresetn, .sys_en, .spi_off, .settled, .expired,
    .cfg_fault, .boot_fault, .run_fault, .cfg_code, .boot_code, .run_code,
    .boot_board, .run_board, .state, .timer_clear,
    .unlock_cfg, .spi_clk_gate, .spi_en, .shutdown_sense_en, .block_buffers,
    .n_shutdown_force, .n_shutdown_rst, .ps_interrupt, .status_word
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int RESET_CYCLES = 2 // Rising edges seen with reset low
) (
  output logic clk,
  output logic aresetn
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    aresetn = 1'b1; // Released on a falling edge like every other input
  end

endmodule

//--- tb_shim_hw_manager.sv
`timescale 1ns/100ps

module tb_shim_hw_manager;

  localparam int N_ROWS     = 15;
  localparam int MAX_CYCLES = N_ROWS * 200; // Longest row stays well below 200 cycles

  localparam logic [1:0] SPI_NORMAL   = 2'd0; // spi_off falls 8 cycles after spi_en
  localparam logic [1:0] SPI_NO_START = 2'd1; // spi_off stuck high
  localparam logic [1:0] SPI_NO_RESET = 2'd2; // spi_off stuck low
  localparam logic [1:0] P_CFG  = 2'd0; // Halt straight from IDLE
  localparam logic [1:0] P_BOOT = 2'd1; // Halt during SPI bring-up
  localparam logic [1:0] P_RUN  = 2'd2; // Reaches RUNNING first

  // {unlock_cfg, spi_clk_gate, spi_en, sense_en, block_buffers, force_n, rst_n, irq}
  localparam logic [7:0] CTRL_RESET = 8'b1000_1010;
  localparam logic [7:0] CTRL_RUN   = 8'b0111_0111; // First RUNNING cycle, irq high

  logic clk, aresetn;
  logic sys_en, ext_shutdown, lock_viol, sys_en_oob, integ_window_oob, bad_trig_cmd;
  logic spi_off = 1'b1; // SPI subsystem comes up in the off state
  logic [shim_pkg::N_BOARDS-1:0] shutdown_sense, over_thresh, dac_boot_fail;
  logic [shim_pkg::N_BOARDS-1:0] bad_dac_cmd, adc_boot_fail, bad_adc_cmd;
  logic unlock_cfg, spi_clk_gate, spi_en, shutdown_sense_en, block_buffers;
  logic n_shutdown_force, n_shutdown_rst, ps_interrupt;
  logic [shim_pkg::STATUS_W-1:0] status_word;

  logic [3:0]  cur_state;
  logic [24:0] cur_code;
  logic [2:0]  cur_board;
  logic [7:0]  ctrl;
  assign cur_state = status_word[3:0];
  assign cur_code  = status_word[28:4];
  assign cur_board = status_word[31:29];
  assign ctrl = {unlock_cfg, spi_clk_gate, spi_en, shutdown_sense_en, block_buffers,
                 n_shutdown_force, n_shutdown_rst, ps_interrupt};

  // Stimulus and expected results, one entry per row
  logic [1:0]  cfg_t    [N_ROWS]; // {sys_en_oob, integ_window_oob}
  logic [1:0]  mode_t   [N_ROWS];
  logic [7:0]  dboot_t  [N_ROWS];
  logic [7:0]  aboot_t  [N_ROWS];
  logic [3:0]  single_t [N_ROWS]; // {drop sys_en, lock_viol, ext_shutdown, bad_trig_cmd}
  logic [7:0]  sense_t  [N_ROWS];
  logic [7:0]  over_t   [N_ROWS];
  logic [7:0]  bdac_t   [N_ROWS];
  logic [7:0]  badc_t   [N_ROWS];
  logic [24:0] code_t   [N_ROWS];
  logic [2:0]  board_t  [N_ROWS];
  logic [1:0]  path_t   [N_ROWS];

  logic [1:0] spi_mode;
  int     en_cycles = 0;
  int     cycles, errors, row, irq_cnt, rst_low_cnt;
  logic   moved; // Some control output left its reset value
  integer seed;

  tb_clk_gen u_clk (.clk, .aresetn);

  shim_hw_manager #(
    .FORCE_DELAY(32'd20), .RESET_PULSE(32'd5), .RESET_DELAY(32'd20),
    .SPI_RESET_WAIT(32'd40), .SPI_START_WAIT(32'd40)
  ) UUT (.*);

  // SPI subsystem model
  always @(negedge clk) begin
    if (spi_en) en_cycles = en_cycles + 1;
    else        en_cycles = 0;
    case (spi_mode)
      SPI_NO_START: spi_off = 1'b1;
      SPI_NO_RESET: spi_off = 1'b0;
      default:      spi_off = (en_cycles < 8);
    endcase
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: DUT did not reach the expected state within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  task automatic add_row(input int r, input logic [1:0] cfg, input logic [1:0] mode,
                         input logic [7:0] dboot, input logic [7:0] aboot,
                         input logic [3:0] single, input logic [7:0] sense,
                         input logic [7:0] over, input logic [7:0] bdac,
                         input logic [7:0] badc, input logic [24:0] code,
                         input logic [2:0] board, input logic [1:0] path);
    cfg_t[r]    = cfg;
    mode_t[r]   = mode;
    dboot_t[r]  = dboot;
    aboot_t[r]  = aboot;
    single_t[r] = single;
    sense_t[r]  = sense;
    over_t[r]   = over;
    bdac_t[r]   = bdac;
    badc_t[r]   = badc;
    code_t[r]   = code;
    board_t[r]  = board;
    path_t[r]   = path;
  endtask

  task automatic fill_table();
    // Clean power-up, then enable drop
    add_row(0, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b1000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_PS_SHUTDOWN, 3'd0, P_RUN);
    add_row(1, 2'b11, SPI_NORMAL, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_SYS_EN_OOB, 3'd0, P_CFG); // Both OOB flags
    add_row(2, 2'b01, SPI_NORMAL, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_INTEG_WINDOW_OOB, 3'd0, P_CFG);
    add_row(3, 2'b00, SPI_NORMAL, 8'h60, 8'h02, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_DAC_BOOT_FAIL, 3'd5, P_BOOT); // DAC beats ADC
    add_row(4, 2'b00, SPI_NORMAL, 8'h00, 8'h90, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_ADC_BOOT_FAIL, 3'd4, P_BOOT);
    add_row(5, 2'b00, SPI_NO_START, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_SPI_START_TIMEOUT, 3'd0, P_BOOT);
    add_row(6, 2'b00, SPI_NO_RESET, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_SPI_RESET_TIMEOUT, 3'd0, P_BOOT);
    add_row(7, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0110, 8'h0c, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_LOCK_VIOL, 3'd0, P_RUN);
    add_row(8, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0010, 8'ha8, 8'h01, 8'h00, 8'h00,
            shim_pkg::STS_SHUTDOWN_SENSE, 3'd3, P_RUN);
    add_row(9, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0011, 8'h00, 8'h40, 8'h00, 8'h00,
            shim_pkg::STS_EXT_SHUTDOWN, 3'd0, P_RUN);
    add_row(10, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0001, 8'h00, 8'hc0, 8'h10, 8'h00,
            shim_pkg::STS_OVER_THRESH, 3'd6, P_RUN);
    add_row(11, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0001, 8'h00, 8'h00, 8'h02, 8'hff,
            shim_pkg::STS_BAD_TRIG_CMD, 3'd0, P_RUN);
    add_row(12, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h14, 8'h01,
            shim_pkg::STS_BAD_DAC_CMD, 3'd2, P_RUN);
    add_row(13, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b0000, 8'h00, 8'h00, 8'h00, 8'h80,
            shim_pkg::STS_BAD_ADC_CMD, 3'd7, P_RUN);
    add_row(14, 2'b00, SPI_NORMAL, 8'h00, 8'h00, 4'b1100, 8'hff, 8'h00, 8'h00, 8'h00,
            shim_pkg::STS_PS_SHUTDOWN, 3'd0, P_RUN); // Enable drop outranks all
  endtask

  // Position in the running-fault priority chain, 0 is highest
  function automatic int rank_of(input logic [24:0] c);
    case (c)
      shim_pkg::STS_PS_SHUTDOWN:    return 0;
      shim_pkg::STS_LOCK_VIOL:      return 1;
      shim_pkg::STS_SHUTDOWN_SENSE: return 2;
      shim_pkg::STS_EXT_SHUTDOWN:   return 3;
      shim_pkg::STS_OVER_THRESH:    return 4;
      shim_pkg::STS_BAD_TRIG_CMD:   return 5;
      shim_pkg::STS_BAD_DAC_CMD:    return 6;
      default:                      return 7;
    endcase
  endfunction

  task automatic report_error(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("Error: %0t ns: row %0d %s is %0h, expected %0h", $time, row, what, got, exp);
  endtask

  // One clock, then sample the registered outputs
  task automatic step();
    @(negedge clk);
    if (ps_interrupt) irq_cnt++;
    if (!n_shutdown_rst) rst_low_cnt++;
    if (ctrl[7:1] != CTRL_RESET[7:1]) moved = 1'b1;
  endtask

  task automatic clear_faults();
    {sys_en_oob, integ_window_oob, lock_viol, ext_shutdown, bad_trig_cmd} = 5'b0;
    {shutdown_sense, over_thresh, bad_dac_cmd, bad_adc_cmd} = 32'h0;
    {dac_boot_fail, adc_boot_fail} = 16'h0;
  endtask

  task automatic run_row(input int r);
    int rank;
    {sys_en_oob, integ_window_oob} = cfg_t[r];
    spi_mode      = mode_t[r];
    dac_boot_fail = dboot_t[r];
    adc_boot_fail = aboot_t[r];
    step();
    irq_cnt     = 0;
    rst_low_cnt = 0;
    moved       = 1'b0;
    sys_en      = 1'b1;
    while (cur_state != shim_pkg::S_RUNNING && cur_state != shim_pkg::S_HALTED) step();
    if (cur_state == shim_pkg::S_RUNNING) begin
      if (ctrl != CTRL_RUN) report_error("controls in RUNNING", 32'(ctrl), 32'(CTRL_RUN));
      if (cur_code != shim_pkg::STS_OK) report_error("code in RUNNING", 32'(cur_code), 32'h1);
      rank = rank_of(code_t[r]);
      // Faults go in during the interrupt cycle, noise only below the winner
      sys_en = !single_t[r][3] && (path_t[r] == P_RUN);
      {lock_viol, ext_shutdown, bad_trig_cmd} = single_t[r][2:0];
      shutdown_sense = sense_t[r];
      over_thresh = over_t[r] | ((rank < 4) ? 8'($random(seed)) : 8'h00);
      bad_dac_cmd = bdac_t[r] | ((rank < 6) ? 8'($random(seed)) : 8'h00);
      bad_adc_cmd = badc_t[r] | ((rank < 7) ? 8'($random(seed)) : 8'h00);
      if (path_t[r] != P_RUN) report_error("path", 32'(P_RUN), 32'(path_t[r]));
      step();
      if (cur_state != shim_pkg::S_RUNNING)
        report_error("state after interrupt cycle", 32'(cur_state), 32'(shim_pkg::S_RUNNING));
      while (cur_state != shim_pkg::S_HALTED) step();
    end
    if (cur_code != code_t[r]) report_error("halt code", 32'(cur_code), 32'(code_t[r]));
    if (cur_board != board_t[r]) report_error("board", 32'(cur_board), 32'(board_t[r]));
    if (ctrl != CTRL_RESET) report_error("controls in HALTED", 32'(ctrl), 32'(CTRL_RESET));
    if (irq_cnt != ((path_t[r] == P_RUN) ? 2 : 1))
      report_error("interrupt cycles", irq_cnt, (path_t[r] == P_RUN) ? 2 : 1);
    if (rst_low_cnt != ((path_t[r] == P_RUN) ? 6 : 0))
      report_error("reset pulse cycles", rst_low_cnt, (path_t[r] == P_RUN) ? 6 : 0);
    if (path_t[r] == P_CFG && moved) report_error("control moved", 32'(moved), 32'h0);
    sys_en = 1'b0; // Back to IDLE
    clear_faults();
    step();
    if (cur_state != shim_pkg::S_IDLE)
      report_error("state after enable drop", 32'(cur_state), 32'(shim_pkg::S_IDLE));
    if (cur_code != shim_pkg::STS_OK) report_error("code in IDLE", 32'(cur_code), 32'h1);
    if (cur_board != 3'd0) report_error("board in IDLE", 32'(cur_board), 32'h0);
  endtask

  initial begin
    errors   = 0;
    row      = 0;
    seed     = 32'hef88;
    sys_en   = 1'b0;
    spi_mode = SPI_NORMAL;
    clear_faults();
    fill_table();
    wait (aresetn);
    step();
    if (cur_state != shim_pkg::S_IDLE)
      report_error("state after reset", 32'(cur_state), 32'(shim_pkg::S_IDLE));
    if (cur_code != shim_pkg::STS_OK) report_error("code after reset", 32'(cur_code), 32'h1);
    if (ctrl != CTRL_RESET) report_error("controls after reset", 32'(ctrl), 32'(CTRL_RESET));
    for (row = 0; row < N_ROWS; row++) begin
      run_row(row);
    end
    $display("Rows run: %0d, errors: %0d", N_ROWS, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
shim_pkg.sv
shim_fault_encoder.sv
shim_seq_timer.sv
shim_power_fsm.sv
shim_hw_manager.sv
tb_clk_gen.sv
tb_shim_hw_manager.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shim hardware manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_shim_hw_manager -f src.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1
